//--- Bender.yml
package:
  name: ntm_tensor

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ntm_tensor_pkg.sv
      - design/ntm_mem_if.sv
      - design/ntm_tensor_memory.sv
      - design/ntm_mem_arbiter.sv
      - design/ntm_tensor_loader.sv
      - design/ntm_tensor_product.sv
      - design/ntm_tensor_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/ntm_tensor_tb.sv

//--- design/ntm_mem_arbiter.sv
/*
 * Memory port arbiter
 * Round-robin between operand loader and product engine
 */

`timescale 1ns/1ps

module ntm_mem_arbiter import ntm_tensor_pkg::*; (
  input logic          CLK,
  input logic          RST,
  ntm_mem_if.responder load_port,
  ntm_mem_if.responder product_port,
  ntm_mem_if.requester mem_port
);

  // High when the engine won the last granted access
  logic last_product;
  logic pick_load;
  logic pick_product;

  //////////////////////////////
  // Winner selection
  //////////////////////////////

  // On a tie the peer that lost last time goes first
  assign pick_load    = load_port.req && (!product_port.req || last_product);
  assign pick_product = product_port.req && !pick_load;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_product <= 1'b0;
    end else if (mem_port.gnt) begin
      // Only a real grant moves the turn
      last_product <= pick_product;
    end
  end

  //////////////////////////////
  // Request forwarding
  //////////////////////////////

  assign mem_port.req = load_port.req || product_port.req;

  always_comb begin
    if (pick_load) begin
      mem_port.we    = load_port.we;
      mem_port.addr  = load_port.addr;
      mem_port.wdata = load_port.wdata;
    end else begin
      mem_port.we    = product_port.we;
      mem_port.addr  = product_port.addr;
      mem_port.wdata = product_port.wdata;
    end
  end

  // Grant back to the winner only
  assign load_port.gnt    = pick_load && mem_port.gnt;
  assign product_port.gnt = pick_product && mem_port.gnt;

  // Engine is the only reader
  assign product_port.rdata = mem_port.rdata;
  assign load_port.rdata    = '0;

endmodule

//--- design/ntm_mem_if.sv
/*
 * Tensor memory port
 * One request and its response between a requester and a responder
 */

`timescale 1ns/1ps

interface ntm_mem_if import ntm_tensor_pkg::*; ();

  // Request side
  logic         req;
  logic         we;
  mem_addr_t    addr;
  tensor_data_t wdata;

  // Response side
  logic         gnt;
  tensor_data_t rdata;

  // Holds req and fields until gnt, read data one cycle after gnt
  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport responder (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

//--- design/ntm_tensor_config.svh
/*
 * Tensor engine configuration
 * Word width, dimension limit and loader buffering
 */

`ifndef NTM_TENSOR_CONFIG_SVH
`define NTM_TENSOR_CONFIG_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Operand, product and accumulator width
`define NTM_DATA_W 16

//////////////////////////////
// Geometry
//////////////////////////////

// Largest I, J or K
`define NTM_DIM_MAX 4

// Loader FIFO entries, power of two
`define NTM_FIFO_DEPTH 4

`endif

//--- design/ntm_tensor_loader.sv
/*
 * Operand loader
 * Buffers host load strobes in a small FIFO and writes them to memory
 */

`timescale 1ns/1ps

`include "ntm_tensor_config.svh"

module ntm_tensor_loader import ntm_tensor_pkg::*; (
  input  logic          CLK,
  input  logic          RST,
  input  logic          LOAD_VALID,
  input  logic          LOAD_BANK,
  input  logic          LOAD_OPERAND,
  input  tensor_index_t LOAD_ROW,
  input  tensor_index_t LOAD_COL,
  input  tensor_data_t  LOAD_DATA,
  output logic          LOAD_FULL,
  ntm_mem_if.requester  mem
);

  // FIFO storage, address and data kept side by side
  mem_addr_t    addr_fifo [`NTM_FIFO_DEPTH];
  tensor_data_t data_fifo [`NTM_FIFO_DEPTH];

  // Pointers wrap on their own, depth is a power of two
  logic [$clog2(`NTM_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(`NTM_FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(`NTM_FIFO_DEPTH):0]   count;

  logic      push;
  logic      pop;
  mem_addr_t load_addr;

  // Bank, operand, row, column
  assign load_addr = {LOAD_BANK, LOAD_OPERAND, LOAD_ROW, LOAD_COL};

  assign LOAD_FULL = (count == `NTM_FIFO_DEPTH);
  assign push      = LOAD_VALID && !LOAD_FULL;
  assign pop       = mem.req && mem.gnt;

  //////////////////////////////
  // Memory side
  //////////////////////////////

  // Head stays on the port until granted
  assign mem.req   = (count != 0);
  assign mem.we    = 1'b1;
  assign mem.addr  = addr_fifo[rd_ptr];
  assign mem.wdata = data_fifo[rd_ptr];

  // Entry payload
  always_ff @(posedge CLK) begin
    if (push) begin
      addr_fifo[wr_ptr] <= load_addr;
      data_fifo[wr_ptr] <= LOAD_DATA;
    end
  end

  // Pointers and fill level
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- design/ntm_tensor_memory.sv
/*
 * Tensor memory
 * Single-port 64-word store, both banks, registered read data
 */

`timescale 1ns/1ps

module ntm_tensor_memory import ntm_tensor_pkg::*; (
  input logic      CLK,
  input logic      RST,
  ntm_mem_if.responder mem
);

  // Whole address space, two banks of A and B
  tensor_data_t store [2**$bits(mem_addr_t)];
  tensor_data_t rdata_q;

  // Port never stalls, every request is served at once
  assign mem.gnt   = mem.req;
  assign mem.rdata = rdata_q;

  // Write side
  always_ff @(posedge CLK) begin
    if (mem.req && mem.we) begin
      store[mem.addr] <= mem.wdata;
    end
  end

  // Read word lands the cycle after the grant
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rdata_q <= '0;
    end else if (mem.req && !mem.we) begin
      rdata_q <= store[mem.addr];
    end
  end

endmodule

//--- design/ntm_tensor_pkg.sv
/*
 * Tensor engine types
 * Word, index, size and address vectors plus the engine FSM states
 */

`include "ntm_tensor_config.svh"

package ntm_tensor_pkg;

  // One operand, product or sum
  typedef logic [`NTM_DATA_W-1:0] tensor_data_t;

  // Row or column index, 0 to DIM_MAX-1
  typedef logic [$clog2(`NTM_DIM_MAX)-1:0] tensor_index_t;

  // Dimension size, 1 to DIM_MAX
  typedef logic [$clog2(`NTM_DIM_MAX):0] tensor_size_t;

  // Bank, operand (0 = A, 1 = B), row, column
  typedef logic [2*$clog2(`NTM_DIM_MAX)+1:0] mem_addr_t;

  // Product engine FSM
  typedef enum logic [2:0] {
    IDLE,
    READ_A,
    READ_B,
    ACCUMULATE,
    EMIT,
    DONE
  } product_state_t;

endpackage

//--- design/ntm_tensor_product.sv
/*
 * Tensor product engine
 * Fetches A[i][k] and B[k][j] over the shared port, accumulates the
 * wrapped products and streams C[i][j] out in row-major order
 */

`timescale 1ns/1ps

module ntm_tensor_product import ntm_tensor_pkg::*; (
  input  logic         CLK,
  input  logic         RST,
  input  logic         START,
  input  logic         BANK,
  input  tensor_size_t SIZE_I,
  input  tensor_size_t SIZE_J,
  input  tensor_size_t SIZE_K,
  output logic         READY,
  output logic         DATA_OUT_ENABLE,
  output tensor_data_t DATA_OUT,
  ntm_mem_if.requester mem
);

  //////////////////////////////
  // State
  //////////////////////////////

  product_state_t state;

  // A word granted last cycle, due on rdata now
  logic data_due;

  tensor_index_t i_q;
  tensor_index_t j_q;
  tensor_index_t k_q;

  // Job setup, sampled on START
  logic         bank_q;
  tensor_size_t size_i_q;
  tensor_size_t size_j_q;
  tensor_size_t size_k_q;

  tensor_data_t a_q;
  tensor_data_t acc;

  tensor_data_t product;
  tensor_data_t sum;
  logic         last_i;
  logic         last_j;
  logic         last_k;

  // End of each loop
  assign last_i = ({1'b0, i_q} == size_i_q - 1'b1);
  assign last_j = ({1'b0, j_q} == size_j_q - 1'b1);
  assign last_k = ({1'b0, k_q} == size_k_q - 1'b1);

  // B word is used straight off rdata, mod 2^16 both steps
  assign product = tensor_data_t'(a_q * mem.rdata);
  assign sum     = acc + product;

  //////////////////////////////
  // Memory requests
  //////////////////////////////

  // A is I x K, B is K x J
  assign mem.req = ((state == READ_A) && !data_due) || (state == READ_B);
  assign mem.we    = 1'b0;
  assign mem.wdata = '0;
  assign mem.addr  = (state == READ_B) ? {bank_q, 1'b1, k_q, j_q}
                                       : {bank_q, 1'b0, i_q, k_q};

  // Outputs decode straight from the FSM
  assign DATA_OUT_ENABLE = (state == EMIT);
  assign DATA_OUT        = acc;
  assign READY           = (state == DONE);

  //////////////////////////////
  // Control path
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      data_due <= 1'b0;
      i_q      <= '0;
      j_q      <= '0;
      k_q      <= '0;
      acc      <= '0;
    end else begin
      case (state)
        IDLE: begin
          // START only counts here
          if (START) begin
            i_q   <= '0;
            j_q   <= '0;
            k_q   <= '0;
            acc   <= '0;
            state <= READ_A;
          end
        end

        READ_A: begin
          // Grant A, then latch A
          if (data_due) begin
            data_due <= 1'b0;
            state    <= READ_B;
          end else if (mem.gnt) begin
            data_due <= 1'b1;
          end
        end

        READ_B: begin
          // Grant B
          if (mem.gnt) state <= ACCUMULATE;
        end

        ACCUMULATE: begin
          // Latch B and fold in A*B
          acc <= sum;
          if (last_k) begin
            state <= EMIT;
          end else begin
            k_q   <= k_q + 1'b1;
            state <= READ_A;
          end
        end

        EMIT: begin
          // Sum on DATA_OUT this cycle, next element is row-major
          acc <= '0;
          k_q <= '0;
          if (last_j) begin
            j_q <= '0;
            if (last_i) begin
              state <= DONE;
            end else begin
              i_q   <= i_q + 1'b1;
              state <= READ_A;
            end
          end else begin
            j_q   <= j_q + 1'b1;
            state <= READ_A;
          end
        end

        DONE: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Data path registers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if ((state == IDLE) && START) begin
      bank_q   <= BANK;
      size_i_q <= SIZE_I;
      size_j_q <= SIZE_J;
      size_k_q <= SIZE_K;
    end
    // A word captured one cycle after its grant
    if ((state == READ_A) && data_due) begin
      a_q <= mem.rdata;
    end
  end

endmodule

//--- design/ntm_tensor_top.sv
/*
 * Tensor contraction engine top
 * Host loader and product engine sharing one tensor memory port
 */

`timescale 1ns/1ps

module ntm_tensor_top import ntm_tensor_pkg::*; (
  input  logic          CLK,
  input  logic          RST,

  // Product control
  input  logic          START,
  input  logic          BANK,
  input  tensor_size_t  SIZE_I,
  input  tensor_size_t  SIZE_J,
  input  tensor_size_t  SIZE_K,
  output logic          READY,

  // Result stream
  output logic          DATA_OUT_ENABLE,
  output tensor_data_t  DATA_OUT,

  // Host operand load
  input  logic          LOAD_VALID,
  input  logic          LOAD_BANK,
  input  logic          LOAD_OPERAND,
  input  tensor_index_t LOAD_ROW,
  input  tensor_index_t LOAD_COL,
  input  tensor_data_t  LOAD_DATA,
  output logic          LOAD_FULL
);

  // Loader to arbiter, engine to arbiter, arbiter to memory
  ntm_mem_if load_bus ();
  ntm_mem_if product_bus ();
  ntm_mem_if memory_bus ();

  // Writer side of the shared port
  ntm_tensor_loader i_loader (
    .CLK          (CLK),
    .RST          (RST),
    .LOAD_VALID   (LOAD_VALID),
    .LOAD_BANK    (LOAD_BANK),
    .LOAD_OPERAND (LOAD_OPERAND),
    .LOAD_ROW     (LOAD_ROW),
    .LOAD_COL     (LOAD_COL),
    .LOAD_DATA    (LOAD_DATA),
    .LOAD_FULL    (LOAD_FULL),
    .mem          (load_bus.requester)
  );

  // Reader side
  ntm_tensor_product i_product (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .BANK            (BANK),
    .SIZE_I          (SIZE_I),
    .SIZE_J          (SIZE_J),
    .SIZE_K          (SIZE_K),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .mem             (product_bus.requester)
  );

  ntm_mem_arbiter i_arbiter (
    .CLK          (CLK),
    .RST          (RST),
    .load_port    (load_bus.responder),
    .product_port (product_bus.responder),
    .mem_port     (memory_bus.requester)
  );

  ntm_tensor_memory i_memory (
    .CLK (CLK),
    .RST (RST),
    .mem (memory_bus.responder)
  );

endmodule

//--- dv/ntm_tensor_tb.sv
/*
 * Tensor engine testbench
 * Random operands and sizes checked against a model of both banks
 */

`timescale 1ns/1ps

`include "ntm_tensor_config.svh"

module ntm_tensor_tb import ntm_tensor_pkg::*; ();

  localparam int CLK_PERIOD  = 4;
  localparam int RUN_COUNT   = 14;
  // Every k step of a 4x4x4 job, plus a full reload of A and B
  localparam int STEP_CYCLES = `NTM_DIM_MAX * `NTM_DIM_MAX * `NTM_DIM_MAX * 4;
  localparam int LOAD_CYCLES = 2 * `NTM_DIM_MAX * `NTM_DIM_MAX * 4;
  localparam int RUN_LIMIT   = (STEP_CYCLES + LOAD_CYCLES) * 4;
  localparam int WATCHDOG_NS = RUN_COUNT * RUN_LIMIT * CLK_PERIOD;

  logic          CLK;
  logic          RST;
  logic          START;
  logic          BANK;
  tensor_size_t  SIZE_I;
  tensor_size_t  SIZE_J;
  tensor_size_t  SIZE_K;
  logic          READY;
  logic          DATA_OUT_ENABLE;
  tensor_data_t  DATA_OUT;
  logic          LOAD_VALID;
  logic          LOAD_BANK;
  logic          LOAD_OPERAND;
  tensor_index_t LOAD_ROW;
  tensor_index_t LOAD_COL;
  tensor_data_t  LOAD_DATA;
  logic          LOAD_FULL;

  // Reference copy of A and B for both banks
  tensor_data_t model_a [2][`NTM_DIM_MAX][`NTM_DIM_MAX];
  tensor_data_t model_b [2][`NTM_DIM_MAX][`NTM_DIM_MAX];

  // Expected results, row-major
  tensor_data_t exp_q [$];

  integer seed;
  int     errors;
  int     checks;
  int     test_start_errors;
  int     enable_count;
  int     ready_count;
  int     enables_at_ready;
  bit     full_seen;
  string  cur_test;

  ntm_tensor_top i_dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .BANK            (BANK),
    .SIZE_I          (SIZE_I),
    .SIZE_J          (SIZE_J),
    .SIZE_K          (SIZE_K),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .LOAD_VALID      (LOAD_VALID),
    .LOAD_BANK       (LOAD_BANK),
    .LOAD_OPERAND    (LOAD_OPERAND),
    .LOAD_ROW        (LOAD_ROW),
    .LOAD_COL        (LOAD_COL),
    .LOAD_DATA       (LOAD_DATA),
    .LOAD_FULL       (LOAD_FULL)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: test %s %s expected %0h actual %0h", cur_test, label, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test          = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    if (errors == test_start_errors) begin
      $display("Test %s: passed", cur_test);
    end else begin
      $display("Test %s: failed with %0d errors", cur_test, errors - test_start_errors);
    end
  endtask

  function automatic tensor_size_t random_size();
    return tensor_size_t'(($unsigned($random(seed)) % `NTM_DIM_MAX) + 1);
  endfunction

  // Sum over k of A[i][k] * B[k][j], mod 2^16
  function automatic tensor_data_t expected_element(input logic bank, input int i,
                                                    input int j, input int k_size);
    logic [31:0]  full_product;
    tensor_data_t sum;
    sum = '0;
    for (int k = 0; k < k_size; k++) begin
      full_product = model_a[bank][i][k] * model_b[bank][k][j];
      sum          = sum + full_product[`NTM_DATA_W-1:0];
    end
    return sum;
  endfunction

  // Called on a falling edge, holds off while the FIFO is full
  task automatic load_element(input logic bank, input logic operand, input int row,
                              input int col);
    tensor_data_t data;
    data = tensor_data_t'($random(seed));
    while (LOAD_FULL) @(negedge CLK);
    LOAD_VALID   = 1'b1;
    LOAD_BANK    = bank;
    LOAD_OPERAND = operand;
    LOAD_ROW     = tensor_index_t'(row);
    LOAD_COL     = tensor_index_t'(col);
    LOAD_DATA    = data;
    if (operand) begin
      model_b[bank][row][col] = data;
    end else begin
      model_a[bank][row][col] = data;
    end
    @(negedge CLK);
    LOAD_VALID = 1'b0;
  endtask

  // Whole A then whole B, random idle gaps up to gap_max
  task automatic load_operands(input logic bank, input int gap_max);
    int gap;
    for (int op = 0; op < 2; op++) begin
      for (int row = 0; row < `NTM_DIM_MAX; row++) begin
        for (int col = 0; col < `NTM_DIM_MAX; col++) begin
          load_element(bank, op[0], row, col);
          gap = $unsigned($random(seed)) % (gap_max + 1);
          repeat (gap) @(negedge CLK);
        end
      end
    end
  endtask

  // Engine idle, so the loader owns every grant
  task automatic drain_loader();
    while (LOAD_FULL) @(negedge CLK);
    repeat (`NTM_FIFO_DEPTH + 2) @(negedge CLK);
  endtask

  task automatic run_product(input logic bank, input bit busy_start, input bit full_size);
    tensor_size_t si;
    tensor_size_t sj;
    tensor_size_t sk;
    int           ready_before;
    int           enable_before;
    int           expected_count;
    int           cycles;
    si = full_size ? tensor_size_t'(`NTM_DIM_MAX) : random_size();
    sj = full_size ? tensor_size_t'(`NTM_DIM_MAX) : random_size();
    sk = full_size ? tensor_size_t'(`NTM_DIM_MAX) : random_size();
    for (int i = 0; i < si; i++) begin
      for (int j = 0; j < sj; j++) begin
        exp_q.push_back(expected_element(bank, i, j, sk));
      end
    end
    expected_count = si * sj;
    ready_before   = ready_count;
    enable_before  = enable_count;
    START  = 1'b1;
    BANK   = bank;
    SIZE_I = si;
    SIZE_J = sj;
    SIZE_K = sk;
    @(negedge CLK);
    START = 1'b0;
    if (busy_start) begin
      @(negedge CLK);
      // Second job on the other bank, engine is mid-run
      START  = 1'b1;
      BANK   = !bank;
      SIZE_I = random_size();
      SIZE_J = random_size();
      SIZE_K = random_size();
      @(negedge CLK);
      START = 1'b0;
    end
    cycles = 0;
    while (ready_count == ready_before && cycles < RUN_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    if (ready_count == ready_before) begin
      $display("Test %s: READY did not pulse within %0d cycles", cur_test, RUN_LIMIT);
      errors++;
      exp_q.delete();
    end else begin
      // Every result must come out ahead of READY
      check_value("enables_before_ready", expected_count,
                  enables_at_ready - enable_before);
    end
    // Room for a stray enable or READY
    repeat (busy_start ? 16 : 4) @(posedge CLK);
    check_value("enable_count", expected_count, enable_count - enable_before);
    check_value("ready_count", 1, ready_count - ready_before);
    check_value("pending_results", 0, exp_q.size());
    @(negedge CLK);
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  // Outputs are registered, stable on the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (LOAD_FULL) full_seen = 1'b1;
      if (READY) begin
        ready_count++;
        // Enables seen up to the READY pulse
        enables_at_ready = enable_count;
      end
      if (DATA_OUT_ENABLE) begin
        enable_count++;
        if (exp_q.size() == 0) begin
          $display("Test %s: result appeared with nothing expected", cur_test);
          errors++;
        end else begin
          check_value("data_out", exp_q.pop_front(), DATA_OUT);
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    seed             = 32'hbe58_33a9;
    errors           = 0;
    checks           = 0;
    enable_count     = 0;
    ready_count      = 0;
    enables_at_ready = 0;
    full_seen        = 1'b0;
    cur_test         = "reset";
    RST              = 1'b1;
    START            = 1'b0;
    BANK             = 1'b0;
    SIZE_I           = tensor_size_t'(1);
    SIZE_J           = tensor_size_t'(1);
    SIZE_K           = tensor_size_t'(1);
    LOAD_VALID       = 1'b0;
    LOAD_BANK        = 1'b0;
    LOAD_OPERAND     = 1'b0;
    LOAD_ROW         = '0;
    LOAD_COL         = '0;
    LOAD_DATA        = '0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;

    begin_test("reset_state");
    check_value("ready", 0, READY);
    check_value("data_out_enable", 0, DATA_OUT_ENABLE);
    check_value("load_full", 0, LOAD_FULL);
    end_test();

    begin_test("idle_loads");
    for (int run = 0; run < 6; run++) begin
      load_operands(1'b0, 2);
      drain_loader();
      run_product(1'b0, 1'b0, 1'b0);
    end
    end_test();

    // Engine reads one bank while the host refills the other
    begin_test("overlapped_loads");
    for (int run = 0; run < 3; run++) begin
      fork
        run_product(run[0], 1'b0, 1'b0);
        begin
          repeat (3) @(negedge CLK);
          load_operands(!run[0], 3);
        end
      join
      drain_loader();
    end
    run_product(1'b1, 1'b0, 1'b0);
    end_test();

    // Back-to-back loads against a long 4x4x4 job
    begin_test("load_backpressure");
    full_seen = 1'b0;
    fork
      run_product(1'b1, 1'b0, 1'b1);
      begin
        repeat (2) @(negedge CLK);
        load_operands(1'b0, 0);
      end
    join
    drain_loader();
    check_value("load_full_seen", 1, full_seen);
    run_product(1'b0, 1'b0, 1'b0);
    end_test();

    begin_test("start_while_busy");
    for (int run = 0; run < 2; run++) begin
      run_product(run[0], 1'b1, 1'b0);
    end
    end_test();

    $display("Tests finished, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+design
design/ntm_tensor_pkg.sv
design/ntm_mem_if.sv
design/ntm_tensor_memory.sv
design/ntm_mem_arbiter.sv
design/ntm_tensor_loader.sv
design/ntm_tensor_product.sv
design/ntm_tensor_top.sv
dv/ntm_tensor_tb.sv
